//--- hdl/alu_fu.sv
// single-cycle alu on rs1 and rs2 only; imm is ignored and issue is taken only while not busy
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module alu_fu (
    input  wire logic                  clock,
    input  wire logic                  rst_n,
    input  wire logic                  ack,
    input  wire ex_pkg::fu_in_packet_t fu_in,
    output ex_pkg::fu_out_packet_t     fu_out,
    output logic                       busy
);

    logic             done_r;
    ex_pkg::rob_tag_t tag_r;
    logic [`XLEN-1:0] value_r;
    logic [`XLEN-1:0] result;
    logic             take;

    assign take = fu_in.issue_valid && !done_r;

    always_comb begin
        case (fu_in.op)
            ex_pkg::op_add: result = fu_in.rs1 + fu_in.rs2;
            ex_pkg::op_sub: result = fu_in.rs1 - fu_in.rs2;
            ex_pkg::op_and: result = fu_in.rs1 & fu_in.rs2;
            ex_pkg::op_or:  result = fu_in.rs1 | fu_in.rs2;
            ex_pkg::op_xor: result = fu_in.rs1 ^ fu_in.rs2;
            // signed compare, 1 or 0
            ex_pkg::op_slt: result = `XLEN'($signed(fu_in.rs1) < $signed(fu_in.rs2));
            ex_pkg::op_sll: result = fu_in.rs1 << fu_in.rs2[4:0];
            ex_pkg::op_srl: result = fu_in.rs1 >> fu_in.rs2[4:0];
            default:        result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            done_r <= 1'b0;
        end else if (take) begin
            done_r <= 1'b1;
        end else if (ack) begin
            done_r <= 1'b0;
        end
    end

    // result payload
    always_ff @(posedge clock) begin
        if (take) begin
            value_r <= result;
            tag_r   <= fu_in.rob_tag;
        end
    end

    assign fu_out.done    = done_r;
    assign fu_out.rob_tag = tag_r;
    assign fu_out.value   = value_r;
    assign busy           = done_r;

endmodule

`default_nettype wire

//--- hdl/cdb_arb.sv
// one broadcast per cycle at most; unchosen units keep their results and wait for a later turn
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module cdb_arb (
    input  wire logic                   clock,
    input  wire logic                   rst_n,
    input  wire ex_pkg::ex_cdb_packet_t ex_cdb,
    output logic [`NUM_FU-1:0]          ack,
    output ex_pkg::cdb_packet_t         cdb
);

    localparam int PTR_W = $clog2(`NUM_FU);

    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] win;
    logic             found;

    // first done unit at or after the pointer, wrapping around
    always_comb begin
        int idx;
        found = 1'b0;
        win   = '0;
        for (int k = 0; k < `NUM_FU; k++) begin
            idx = int'(ptr) + k;
            if (idx >= `NUM_FU) begin
                idx = idx - `NUM_FU;
            end
            if (!found && ex_cdb[idx].done) begin
                found = 1'b1;
                win   = PTR_W'(idx);
            end
        end
    end

    always_comb begin
        ack         = '0;
        cdb.valid   = found;
        cdb.rob_tag = found ? ex_cdb[win].rob_tag : '0;
        cdb.value   = found ? ex_cdb[win].value : '0;
        if (found) begin
            ack[win] = 1'b1;
        end
    end

    // next search starts just past the winner
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (found) begin
            ptr <= (win == PTR_W'(`NUM_FU - 1)) ? '0 : win + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/ex.sv
// unit map is fixed (0-1 alu, 2 load, 3 store, 4-5 mult); the load always wins the memory port
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex (
    input  wire logic                  clock,
    input  wire logic                  rst_n,
    input  wire ex_pkg::rs_ex_packet_t rs_ex,
    input  wire logic [`XLEN-1:0]      dmem_rdata,
    input  wire logic [`NUM_FU-1:0]    ack,
    output ex_pkg::fu_mem_packet_t     fu_mem,
    output ex_pkg::ex_cdb_packet_t     ex_cdb,
    output logic [`NUM_FU-1:0]         fu_free,
    output logic [`NUM_FU-1:0]         fu_done
);

    ex_pkg::fu_mem_packet_t ld_mem;
    ex_pkg::fu_mem_packet_t st_mem;
    logic                   ld_req;
    logic                   st_req;
    logic                   ld_ack;
    logic                   st_ack;
    logic [`NUM_FU-1:0]     busy;

    // load first, store only when the load is quiet
    assign ld_ack = ld_req;
    assign st_ack = st_req && !ld_req;
    assign fu_mem = ld_ack ? ld_mem : (st_ack ? st_mem : '0);

    assign fu_free = ~busy;
    // one pulse per result taken by the cdb
    assign fu_done = ack;

    alu_fu u_alu0 (
        .clock  (clock),
        .rst_n  (rst_n),
        .ack    (ack[0]),
        .fu_in  (rs_ex[0]),
        .fu_out (ex_cdb[0]),
        .busy   (busy[0])
    );

    alu_fu u_alu1 (
        .clock  (clock),
        .rst_n  (rst_n),
        .ack    (ack[1]),
        .fu_in  (rs_ex[1]),
        .fu_out (ex_cdb[1]),
        .busy   (busy[1])
    );

    load_fu u_load (
        .clock      (clock),
        .rst_n      (rst_n),
        .ack        (ack[2]),
        .fu_in      (rs_ex[2]),
        .mem_ack    (ld_ack),
        .dmem_rdata (dmem_rdata),
        .mem_req    (ld_req),
        .fu_mem     (ld_mem),
        .fu_out     (ex_cdb[2]),
        .busy       (busy[2])
    );

    store_fu u_store (
        .clock   (clock),
        .rst_n   (rst_n),
        .ack     (ack[3]),
        .fu_in   (rs_ex[3]),
        .mem_ack (st_ack),
        .mem_req (st_req),
        .fu_mem  (st_mem),
        .fu_out  (ex_cdb[3]),
        .busy    (busy[3])
    );

    mult_fu u_mult0 (
        .clock  (clock),
        .rst_n  (rst_n),
        .ack    (ack[4]),
        .fu_in  (rs_ex[4]),
        .fu_out (ex_cdb[4]),
        .busy   (busy[4])
    );

    mult_fu u_mult1 (
        .clock  (clock),
        .rst_n  (rst_n),
        .ack    (ack[5]),
        .fu_in  (rs_ex[5]),
        .fu_out (ex_cdb[5]),
        .busy   (busy[5])
    );

endmodule

`default_nettype wire

//--- hdl/ex_cfg.svh
// fixed RV32 word widths only; unit indices 0-1 alu, 2 load, 3 store, 4-5 mult are wired in ex
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// data and address width
`define XLEN 32

// functional unit count, the index map is fixed
`define NUM_FU 6

// rob tag width
`define ROB_TAG_W 5

// multiplier latency in cycles from the issue edge
`define MULT_LAT 4

`endif

//--- hdl/ex_pkg.sv
// shared execute stage types; unit count and widths are taken from ex_cfg.svh at compile time
`default_nettype none

`include "ex_cfg.svh"

package ex_pkg;

    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    // alu operation code, ignored by load, store and mult units
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_slt = 4'd5,
        op_sll = 4'd6,
        op_srl = 4'd7
    } alu_op_e;

    // one issued instruction for one unit
    typedef struct packed {
        logic             issue_valid;
        alu_op_e          op;
        rob_tag_t         rob_tag;
        logic [`XLEN-1:0] rs1;
        logic [`XLEN-1:0] rs2;
        logic [`XLEN-1:0] imm;
    } fu_in_packet_t;

    typedef fu_in_packet_t [`NUM_FU-1:0] rs_ex_packet_t;

    // held result of one unit
    typedef struct packed {
        logic             done;
        rob_tag_t         rob_tag;
        logic [`XLEN-1:0] value;
    } fu_out_packet_t;

    // word-wide data memory request
    typedef struct packed {
        logic             valid;
        logic             we;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } fu_mem_packet_t;

    typedef fu_out_packet_t [`NUM_FU-1:0] ex_cdb_packet_t;

    typedef struct packed {
        logic             valid;
        rob_tag_t         rob_tag;
        logic [`XLEN-1:0] value;
    } cdb_packet_t;

endpackage

`default_nettype wire

//--- hdl/ex_top.sv
// execute stage top; issue to unit i only while fu_free[i] is high and answer reads one cycle later
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_top (
    input  wire logic                  clock,
    input  wire logic                  rst_n,
    input  wire ex_pkg::rs_ex_packet_t rs_ex,
    input  wire logic [`XLEN-1:0]      dmem_rdata,
    output ex_pkg::fu_mem_packet_t     fu_mem,
    output ex_pkg::cdb_packet_t        cdb,
    output logic [`NUM_FU-1:0]         fu_free,
    output logic [`NUM_FU-1:0]         fu_done
);

    // held unit results and the arbiter's one-hot grant
    ex_pkg::ex_cdb_packet_t ex_cdb;
    logic [`NUM_FU-1:0]     ack;

    ex u_ex (
        .clock      (clock),
        .rst_n      (rst_n),
        .rs_ex      (rs_ex),
        .dmem_rdata (dmem_rdata),
        .ack        (ack),
        .fu_mem     (fu_mem),
        .ex_cdb     (ex_cdb),
        .fu_free    (fu_free),
        .fu_done    (fu_done)
    );

    cdb_arb u_cdb_arb (
        .clock  (clock),
        .rst_n  (rst_n),
        .ex_cdb (ex_cdb),
        .ack    (ack),
        .cdb    (cdb)
    );

endmodule

`default_nettype wire

//--- hdl/load_fu.sv
// word loads only at rs1+imm with no alignment check; read data is expected one cycle after the grant
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module load_fu (
    input  wire logic                  clock,
    input  wire logic                  rst_n,
    input  wire logic                  ack,
    input  wire ex_pkg::fu_in_packet_t fu_in,
    input  wire logic                  mem_ack,
    input  wire logic [`XLEN-1:0]      dmem_rdata,
    output logic                       mem_req,
    output ex_pkg::fu_mem_packet_t     fu_mem,
    output ex_pkg::fu_out_packet_t     fu_out,
    output logic                       busy
);

    typedef enum logic [1:0] {
        ld_idle,
        ld_req,
        ld_wait,
        ld_done
    } ld_state_e;

    ld_state_e        state;
    logic [`XLEN-1:0] addr_r;
    ex_pkg::rob_tag_t tag_r;
    logic [`XLEN-1:0] value_r;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state <= ld_idle;
        end else begin
            case (state)
                ld_idle: if (fu_in.issue_valid) state <= ld_req;
                ld_req:  if (mem_ack) state <= ld_wait;
                // data arrives during this cycle
                ld_wait: state <= ld_done;
                ld_done: if (ack) state <= ld_idle;
                default: state <= ld_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == ld_idle && fu_in.issue_valid) begin
            addr_r <= fu_in.rs1 + fu_in.imm;
            tag_r  <= fu_in.rob_tag;
        end
        if (state == ld_wait) begin
            value_r <= dmem_rdata;
        end
    end

    assign mem_req      = (state == ld_req);
    assign fu_mem.valid = mem_req;
    assign fu_mem.we    = 1'b0;
    assign fu_mem.addr  = addr_r;
    assign fu_mem.wdata = '0;

    assign fu_out.done    = (state == ld_done);
    assign fu_out.rob_tag = tag_r;
    assign fu_out.value   = value_r;
    assign busy           = (state != ld_idle);

endmodule

`default_nettype wire

//--- hdl/mult_fu.sv
// fixed MULT_LAT multiplier returning the low word of rs1*rs2; op and imm are ignored
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module mult_fu (
    input  wire logic                  clock,
    input  wire logic                  rst_n,
    input  wire logic                  ack,
    input  wire ex_pkg::fu_in_packet_t fu_in,
    output ex_pkg::fu_out_packet_t     fu_out,
    output logic                       busy
);

    localparam int CNT_W = $clog2(`MULT_LAT + 1);

    logic             running;
    logic             done_r;
    logic [CNT_W-1:0] count;
    logic [`XLEN-1:0] a_r;
    logic [`XLEN-1:0] b_r;
    ex_pkg::rob_tag_t tag_r;
    logic [`XLEN-1:0] value_r;
    logic             take;
    logic             finish;

    assign take   = fu_in.issue_valid && !running && !done_r;
    assign finish = running && (count == '0);

    // countdown so done rises MULT_LAT edges after issue
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            running <= 1'b0;
            done_r  <= 1'b0;
            count   <= '0;
        end else begin
            if (take) begin
                running <= 1'b1;
                count   <= CNT_W'(`MULT_LAT - 1);
            end else if (finish) begin
                running <= 1'b0;
                done_r  <= 1'b1;
            end else if (running) begin
                count <= count - 1'b1;
            end else if (ack) begin
                done_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            a_r   <= fu_in.rs1;
            b_r   <= fu_in.rs2;
            tag_r <= fu_in.rob_tag;
        end
        if (finish) begin
            // low word only
            value_r <= a_r * b_r;
        end
    end

    assign fu_out.done    = done_r;
    assign fu_out.rob_tag = tag_r;
    assign fu_out.value   = value_r;
    assign busy           = running || done_r;

endmodule

`default_nettype wire

//--- hdl/store_fu.sv
// word stores only, rs2 to rs1+imm; no ordering against loads and the broadcast value is always 0
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module store_fu (
    input  wire logic                  clock,
    input  wire logic                  rst_n,
    input  wire logic                  ack,
    input  wire ex_pkg::fu_in_packet_t fu_in,
    input  wire logic                  mem_ack,
    output logic                       mem_req,
    output ex_pkg::fu_mem_packet_t     fu_mem,
    output ex_pkg::fu_out_packet_t     fu_out,
    output logic                       busy
);

    logic             req_r;
    logic             done_r;
    logic [`XLEN-1:0] addr_r;
    logic [`XLEN-1:0] data_r;
    ex_pkg::rob_tag_t tag_r;
    logic             take;

    assign take = fu_in.issue_valid && !req_r && !done_r;

    // request held until granted, then done until the cdb takes it
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            req_r  <= 1'b0;
            done_r <= 1'b0;
        end else if (take) begin
            req_r <= 1'b1;
        end else if (req_r && mem_ack) begin
            req_r  <= 1'b0;
            done_r <= 1'b1;
        end else if (ack) begin
            done_r <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            addr_r <= fu_in.rs1 + fu_in.imm;
            data_r <= fu_in.rs2;
            tag_r  <= fu_in.rob_tag;
        end
    end

    assign mem_req      = req_r;
    assign fu_mem.valid = req_r;
    assign fu_mem.we    = 1'b1;
    assign fu_mem.addr  = addr_r;
    assign fu_mem.wdata = data_r;

    assign fu_out.done    = done_r;
    assign fu_out.rob_tag = tag_r;
    assign fu_out.value   = '0;
    assign busy           = req_r || done_r;

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module ex_tb -f sim.f -o ex_sim \
    && ./obj_dir/ex_sim > sim.log 2>&1
grep -qx '>>> PASS' sim.log 2>/dev/null && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- sim.f
+incdir+hdl
hdl/ex_pkg.sv
hdl/alu_fu.sv
hdl/mult_fu.sv
hdl/load_fu.sv
hdl/store_fu.sv
hdl/ex.sv
hdl/cdb_arb.sv
hdl/ex_top.sv
tests/ex_tb.sv

//--- tests/ex_tb.sv
// checks ex_top only at word addresses below 0x100; the memory model aliases anything higher onto 64 words
`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_tb;

    localparam int NUM_TAGS     = 1 << `ROB_TAG_W;
    localparam int TOTAL_ISSUES = 26;
    // worst case per result: multiplier latency, a full round-robin wait and some slack
    localparam int PER_RESULT   = `MULT_LAT + `NUM_FU + 6;
    localparam int TIMEOUT_NS   = (TOTAL_ISSUES * PER_RESULT + 20) * 10;

    logic                   clock;
    logic                   rst_n;
    ex_pkg::rs_ex_packet_t  rs_ex;
    logic [`XLEN-1:0]       dmem_rdata;
    ex_pkg::fu_mem_packet_t fu_mem;
    ex_pkg::cdb_packet_t    cdb;
    logic [`NUM_FU-1:0]     fu_free;
    logic [`NUM_FU-1:0]     fu_done;

    // scoreboard, indexed by rob tag
    logic [`XLEN-1:0]       exp_val [0:NUM_TAGS-1];
    int                     issue_cyc [0:NUM_TAGS-1];
    int                     min_lat [0:NUM_TAGS-1];
    logic [NUM_TAGS-1:0]    live;
    logic [`XLEN-1:0]       mem [0:63];
    logic [`XLEN-1:0]       shadow [0:63];
    ex_pkg::rs_ex_packet_t  staged;
    ex_pkg::rob_tag_t       next_tag;
    ex_pkg::rob_tag_t       mon_tag;
    logic [`NUM_FU-1:0]     owed;
    integer                 seed;
    int                     cyc;
    int                     errors;
    int                     err_mark;
    int                     passed;
    int                     failed;
    int                     pending;
    int                     bcast;
    string                  cur_test;

    ex_top uut (
        .clock      (clock),
        .rst_n      (rst_n),
        .rs_ex      (rs_ex),
        .dmem_rdata (dmem_rdata),
        .fu_mem     (fu_mem),
        .cdb        (cdb),
        .fu_free    (fu_free),
        .fu_done    (fu_done)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cyc <= cyc + 1;
    end

    // data memory, read data one cycle after the granted request
    always @(posedge clock) begin
        if (fu_mem.valid && fu_mem.we) begin
            mem[fu_mem.addr[7:2]] <= fu_mem.wdata;
        end
        if (fu_mem.valid && !fu_mem.we) begin
            dmem_rdata <= mem[fu_mem.addr[7:2]];
        end
    end

    function automatic logic [31:0] fill_word(input int idx);
        logic [31:0] byte_addr;
        byte_addr = 32'(idx) << 2;
        return (byte_addr * 32'h9e3779b1) ^ 32'h5a5a5a5a;
    endfunction

    function automatic logic [31:0] alu_model(input ex_pkg::alu_op_e op,
                                              input logic [31:0] a, input logic [31:0] b);
        case (op)
            ex_pkg::op_add: return a + b;
            ex_pkg::op_sub: return a + ~b + 32'd1;
            ex_pkg::op_and: return a & b;
            ex_pkg::op_or:  return a | b;
            ex_pkg::op_xor: return a ^ b;
            ex_pkg::op_slt: begin
                // differing signs decide it, otherwise an unsigned compare works
                if (a[31] != b[31]) return {31'd0, a[31]};
                return {31'd0, a < b};
            end
            ex_pkg::op_sll: return a << b[4:0];
            ex_pkg::op_srl: return a >> b[4:0];
            default:        return 32'd0;
        endcase
    endfunction

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("Mismatch in %s (%s): expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    // record the expected result and place the packet for unit fu
    task automatic stage(input int fu, input ex_pkg::alu_op_e op, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] imm);
        ex_pkg::fu_in_packet_t p;
        logic [31:0]           addr;
        logic [31:0]           expv;
        int                    lat;
        addr = a + imm;
        p.issue_valid = 1'b1;
        p.op          = op;
        p.rob_tag     = next_tag;
        p.rs1         = a;
        p.rs2         = b;
        p.imm         = imm;
        case (fu)
            0, 1: begin
                expv = alu_model(op, a, b);
                lat  = 1;
            end
            2: begin
                expv = shadow[addr[7:2]];
                lat  = 2;
            end
            3: begin
                expv = 32'd0;
                lat  = 1;
                shadow[addr[7:2]] = b;
            end
            default: begin
                expv = a * b;
                lat  = `MULT_LAT;
            end
        endcase
        exp_val[next_tag] = expv;
        min_lat[next_tag] = lat;
        live[next_tag]    = 1'b1;
        pending++;
        staged[fu] = p;
        next_tag   = next_tag + 1'b1;
    endtask

    task automatic launch(input logic [`NUM_FU-1:0] mask);
        @(posedge clock);
        for (int i = 0; i < `NUM_FU; i++) begin
            if (mask[i]) begin
                rs_ex[i] <= staged[i];
                issue_cyc[staged[i].rob_tag] = cyc + 1;
                staged[i] = '0;
            end else begin
                rs_ex[i] <= '0;
            end
        end
    endtask

    task automatic fire(input logic [`NUM_FU-1:0] mask);
        @(negedge clock);
        while ((fu_free & mask) != mask) @(negedge clock);
        launch(mask);
        launch('0);
    endtask

    task automatic drain();
        while (pending != 0) @(posedge clock);
    endtask

    task automatic wait_mem(input logic we);
        @(negedge clock);
        while (!(fu_mem.valid && fu_mem.we == we)) @(negedge clock);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            passed++;
            $display("test %s: ok", cur_test);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", cur_test, errors - err_mark);
        end
    endtask

    // cdb monitor and free/done tracking
    always @(negedge clock) begin
        if (rst_n) begin
            assert ($onehot0(fu_done) && cdb.valid == (fu_done != '0)) else begin
                errors++;
                $display("fu_done %b does not match one cdb broadcast in %s", fu_done, cur_test);
            end
            for (int i = 0; i < `NUM_FU; i++) begin
                if (owed[i]) begin
                    assert (!fu_free[i]) else begin
                        errors++;
                        $display("unit %0d became free before its done pulse in %s", i, cur_test);
                    end
                    if (fu_done[i]) owed[i] = 1'b0;
                end
                if (rs_ex[i].issue_valid) owed[i] = 1'b1;
            end
            if (cdb.valid) begin
                mon_tag = cdb.rob_tag;
                bcast++;
                assert (live[mon_tag]) else begin
                    errors++;
                    $display("cdb broadcast tag %0d which was not in flight in %s",
                             mon_tag, cur_test);
                end
                if (live[mon_tag]) begin
                    check_word($sformatf("tag %0d value", mon_tag), exp_val[mon_tag], cdb.value);
                    assert (cyc - issue_cyc[mon_tag] >= min_lat[mon_tag]) else begin
                        errors++;
                        $display("tag %0d reached the cdb too early in %s", mon_tag, cur_test);
                    end
                    live[mon_tag] = 1'b0;
                    pending--;
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the tests finished");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] rnd;
        logic [31:0] sdata;
        int          first;
        int          mark;
        rst_n      = 1'b0;
        rs_ex      = '0;
        dmem_rdata = '0;
        staged     = '0;
        live       = '0;
        owed       = '0;
        next_tag   = '0;
        seed       = 94286;
        cyc        = 0;
        errors     = 0;
        passed     = 0;
        failed     = 0;
        pending    = 0;
        bcast      = 0;
        cur_test   = "reset";
        for (int i = 0; i < 64; i++) begin
            mem[i]    = fill_word(i);
            shadow[i] = fill_word(i);
        end
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;

        begin_test("reset");
        @(negedge clock);
        check_word("cdb.valid", 32'd0, {31'd0, cdb.valid});
        check_word("fu_mem.valid", 32'd0, {31'd0, fu_mem.valid});
        check_word("fu_done", 32'd0, 32'(fu_done));
        check_word("fu_free", 32'(6'h3f), 32'(fu_free));
        end_test();

        begin_test("alu_mult_random");
        for (int r = 0; r < 4; r++) begin
            for (int u = 0; u < 6; u++) begin
                if (u == 2 || u == 3) continue;
                rnd = $random(seed);
                ra  = $random(seed);
                rb  = $random(seed);
                stage(u, ex_pkg::alu_op_e'({1'b0, rnd[2:0]}), ra, rb, 32'd0);
            end
            fire(6'b110011);
        end
        drain();
        end_test();

        begin_test("store_then_load");
        sdata = $random(seed);
        stage(3, ex_pkg::op_add, 32'h40, sdata, 32'h8);
        fire(6'b001000);
        wait_mem(1'b1);
        check_word("store addr", 32'h48, fu_mem.addr);
        check_word("store data", sdata, fu_mem.wdata);
        drain();
        stage(2, ex_pkg::op_add, 32'h44, 32'd0, 32'h4);
        fire(6'b000100);
        drain();
        end_test();

        begin_test("memory_priority");
        sdata = $random(seed);
        stage(2, ex_pkg::op_add, 32'h10, 32'd0, 32'h4);
        stage(3, ex_pkg::op_add, 32'h70, sdata, 32'h8);
        fire(6'b001100);
        @(negedge clock);
        while (!fu_mem.valid) @(negedge clock);
        first = cyc;
        check_word("first request we", 32'd0, {31'd0, fu_mem.we});
        check_word("first request addr", 32'h14, fu_mem.addr);
        wait_mem(1'b1);
        // the load is granted at once, so the held store goes out in the next cycle
        assert (cyc == first + 1) else begin
            errors++;
            $display("store request was not granted right after the load in %s", cur_test);
        end
        check_word("held store addr", 32'h78, fu_mem.addr);
        check_word("held store data", sdata, fu_mem.wdata);
        drain();
        end_test();

        begin_test("cdb_backpressure");
        @(negedge clock);
        while (fu_free != '1) @(negedge clock);
        mark = bcast;
        for (int u = 0; u < 2; u++) begin
            rnd = $random(seed);
            ra  = $random(seed);
            rb  = $random(seed);
            stage(u, ex_pkg::alu_op_e'({1'b0, rnd[2:0]}), ra, rb, 32'd0);
        end
        sdata = $random(seed);
        stage(2, ex_pkg::op_add, 32'h20, 32'd0, 32'd0);
        stage(3, ex_pkg::op_add, 32'h30, sdata, 32'd0);
        ra = $random(seed);
        rb = $random(seed);
        stage(4, ex_pkg::op_add, ra, rb, 32'd0);
        stage(5, ex_pkg::op_add, rb, ra ^ 32'h0f0f_1234, 32'd0);
        // staggered so that all six raise done at the same edge
        launch(6'b110000);
        launch('0);
        launch(6'b000100);
        launch(6'b001000);
        launch(6'b000011);
        launch('0);
        drain();
        check_word("broadcast count", 32'd6, 32'(bcast - mark));
        end_test();

        $display("tests passed: %0d, tests failed: %0d, check errors: %0d",
                 passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
